// File: common/mcu_pkg.sv
// Shared widths, register map, opcodes and the command word views
// used by the sequencer, the program memory and the register slaves.

package mcu_pkg;

  // program memory
  localparam int MEM_AW = 6;
  localparam int RAM_DEPTH = 32;
  localparam int CMD_W = 32;
  localparam logic [MEM_AW-1:0] BOOT_BASE = 6'd32;

  // register bus
  localparam int BUS_AW = 8;
  localparam int BUS_DW = 16;
  localparam int WAIT_W = 16;
  // address bit that picks the slave, 0 gpio and 1 soc
  localparam int BUS_SEL_BIT = 4;

  localparam logic [BUS_AW-1:0] GPIO_OUT_ADDR = 8'h00;
  localparam logic [BUS_AW-1:0] GPIO_SET_ADDR = 8'h01;
  localparam logic [BUS_AW-1:0] GPIO_CLR_ADDR = 8'h02;
  localparam logic [BUS_AW-1:0] GPIO_IN_ADDR = 8'h03;
  localparam logic [BUS_AW-1:0] SOC_EXIT_ADDR = 8'h10;
  localparam logic [BUS_AW-1:0] SOC_SCRATCH_ADDR = 8'h11;

  // unlisted codes halt like OP_HALT
  typedef enum logic [3:0] {
    OP_WRITE     = 4'h1,
    OP_READ      = 4'h2,
    OP_WRITE_ACC = 4'h3,
    OP_WAIT      = 4'h4,
    OP_JUMP      = 4'h5,
    OP_HALT      = 4'hF
  } op_e;

  typedef struct packed {
    op_e               op;
    logic [BUS_AW-1:0] addr;
    logic [BUS_DW-1:0] data;
    logic [3:0]        spare;
  } bus_cmd_t;

  typedef struct packed {
    op_e               op;
    logic [MEM_AW-1:0] target;
    logic [WAIT_W-1:0] count;
    logic [5:0]        spare;
  } ctrl_cmd_t;

  // both views keep op in the top nibble
  typedef union packed {
    bus_cmd_t  bus;
    ctrl_cmd_t ctrl;
  } cmd_u;

endpackage

// File: common/mcu_bus_if.sv
// Four-phase req/ack register bus between the sequencer and the slaves,
// with master and slave views.

interface mcu_bus_if;
  import mcu_pkg::*;

  logic              req;
  logic              ack;
  logic              we;
  logic [BUS_AW-1:0] addr;
  logic [BUS_DW-1:0] wdata;
  logic [BUS_DW-1:0] rdata;

  modport master (
    output req, we, addr, wdata,
    input  ack, rdata
  );

  modport slave (
    input  req, we, addr, wdata,
    output ack, rdata
  );

endinterface

// File: mcu/cmd_sequencer.sv
// Command sequencer FSM: fetches command words, runs four-phase bus
// transactions, counts waits, follows jumps and halts.

module cmd_sequencer (
  input  logic                        clk_gen,
  input  logic                        rst_n,
  input  logic                        fetch_enable_i,
  input  logic                        boot_select_i,
  input  mcu_pkg::cmd_u               fetch_data_i,
  output logic [mcu_pkg::MEM_AW-1:0]  fetch_addr_o,
  mcu_bus_if.master                   bus
);
  import mcu_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    DECODE,
    REQ,
    RELEASE,
    WAIT,
    DONE
  } state_e;

  state_e            state_q;
  logic [MEM_AW-1:0] pc_q;
  logic [BUS_DW-1:0] acc_q;
  logic [WAIT_W-1:0] wait_cnt_q;
  logic              req_q;
  logic              we_q;
  logic [BUS_AW-1:0] addr_q;
  logic [BUS_DW-1:0] wdata_q;
  op_e               op;

  // memory reads pc every cycle, so the word is ready one cycle after pc moves
  assign fetch_addr_o = pc_q;
  assign op           = fetch_data_i.bus.op;

  assign bus.req   = req_q;
  assign bus.we    = we_q;
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      pc_q       <= '0;
      acc_q      <= '0;
      wait_cnt_q <= '0;
      req_q      <= 1'b0;
      we_q       <= 1'b0;
      addr_q     <= '0;
      wdata_q    <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (fetch_enable_i) begin
            pc_q    <= boot_select_i ? BOOT_BASE : '0;
            state_q <= FETCH;
          end
        end
        FETCH: begin
          state_q <= DECODE;
        end
        DECODE: begin
          case (op)
            OP_WRITE, OP_READ, OP_WRITE_ACC: begin
              pc_q    <= pc_q + 1'b1;
              req_q   <= 1'b1;
              we_q    <= (op != OP_READ);
              addr_q  <= fetch_data_i.bus.addr;
              // write-acc sends acc xor immediate
              if (op == OP_WRITE_ACC) begin
                wdata_q <= acc_q ^ fetch_data_i.bus.data;
              end else begin
                wdata_q <= fetch_data_i.bus.data;
              end
              state_q <= REQ;
            end
            OP_WAIT: begin
              pc_q       <= pc_q + 1'b1;
              wait_cnt_q <= fetch_data_i.ctrl.count;
              state_q    <= WAIT;
            end
            OP_JUMP: begin
              pc_q    <= fetch_data_i.ctrl.target;
              state_q <= FETCH;
            end
            default: begin
              state_q <= DONE;
            end
          endcase
        end
        REQ: begin
          if (bus.ack) begin
            req_q <= 1'b0;
            if (!we_q) begin
              acc_q <= bus.rdata;
            end
            state_q <= RELEASE;
          end
        end
        RELEASE: begin
          // no new req until the slave has dropped ack
          if (!bus.ack) begin
            state_q <= DECODE;
          end
        end
        WAIT: begin
          if (wait_cnt_q == '0) begin
            state_q <= DECODE;
          end else begin
            wait_cnt_q <= wait_cnt_q - 1'b1;
          end
        end
        DONE: begin
          state_q <= DONE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // a request is held until the selected slave answers
  assert property (@(posedge clk_gen) disable iff (!rst_n)
    bus.req && !bus.ack |=> bus.req);

  // payload does not move under an open request
  assert property (@(posedge clk_gen) disable iff (!rst_n)
    bus.req && !bus.ack |=> $stable(bus.addr) && $stable(bus.wdata) && $stable(bus.we));

endmodule

// File: mcu/prog_mem.sv
// Program memory: 32-word RAM loaded over a four-phase host port,
// the fixed boot ROM, and a synchronous fetch port.

module prog_mem (
  input  logic                        clk_gen,
  input  logic                        rst_n,
  input  logic [mcu_pkg::MEM_AW-1:0]  fetch_addr_i,
  input  logic                        load_req_i,
  input  logic [mcu_pkg::MEM_AW-1:0]  load_addr_i,
  input  logic [mcu_pkg::CMD_W-1:0]   load_data_i,
  output mcu_pkg::cmd_u               fetch_data_o,
  output logic                        load_ack_o
);
  import mcu_pkg::*;

  logic [CMD_W-1:0] ram_q [RAM_DEPTH];
  cmd_u             rom_word;

  // ack follows req by one cycle in both directions
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      load_ack_o <= 1'b0;
    end else begin
      load_ack_o <= load_req_i;
    end
  end

  // one write per handshake, rom region acked but dropped
  always_ff @(posedge clk_gen) begin
    if (load_req_i && !load_ack_o && !load_addr_i[MEM_AW-1]) begin
      ram_q[load_addr_i[MEM_AW-2:0]] <= load_data_i;
    end
  end

  // boot rom, anything past it reads as halt
  always_comb begin
    rom_word         = '0;
    rom_word.ctrl.op = OP_HALT;
    if (fetch_addr_i[MEM_AW-1:2] == BOOT_BASE[MEM_AW-1:2]) begin
      case (fetch_addr_i[1:0])
        2'd0: begin
          rom_word.bus.op   = OP_WRITE;
          rom_word.bus.addr = GPIO_OUT_ADDR;
          rom_word.bus.data = 16'h00A5;
        end
        2'd1: begin
          rom_word.bus.op   = OP_READ;
          rom_word.bus.addr = GPIO_IN_ADDR;
        end
        2'd2: begin
          rom_word.bus.op   = OP_WRITE_ACC;
          rom_word.bus.addr = SOC_EXIT_ADDR;
          rom_word.bus.data = 16'h0000;
        end
        default: begin
          rom_word.ctrl.op = OP_HALT;
        end
      endcase
    end
  end

  always_ff @(posedge clk_gen) begin
    if (!fetch_addr_i[MEM_AW-1]) begin
      fetch_data_o <= ram_q[fetch_addr_i[MEM_AW-2:0]];
    end else begin
      fetch_data_o <= rom_word;
    end
  end

endmodule

// File: mcu/gpio_regs.sv
// GPIO register slave: output register with set and clear aliases
// and a registered input readback.

module gpio_regs (
  input  logic                        clk_gen,
  input  logic                        rst_n,
  mcu_bus_if.slave                    bus,
  input  logic [mcu_pkg::BUS_DW-1:0]  gpio_i,
  output logic [mcu_pkg::BUS_DW-1:0]  gpio_o
);
  import mcu_pkg::*;

  logic              ack_q;
  logic              access;
  logic [BUS_DW-1:0] out_q;
  logic [BUS_DW-1:0] in_q;
  logic [BUS_DW-1:0] rdata_q;

  // first request cycle raises ack
  assign access = bus.req && !ack_q;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      out_q <= '0;
    end else begin
      ack_q <= bus.req;
      if (access && bus.we) begin
        case (bus.addr)
          GPIO_OUT_ADDR: out_q <= bus.wdata;
          GPIO_SET_ADDR: out_q <= out_q | bus.wdata;
          GPIO_CLR_ADDR: out_q <= out_q & ~bus.wdata;
          default:       out_q <= out_q;
        endcase
      end
    end
  end

  always_ff @(posedge clk_gen) begin
    in_q <= gpio_i;
    if (access && !bus.we) begin
      case (bus.addr)
        GPIO_OUT_ADDR, GPIO_SET_ADDR, GPIO_CLR_ADDR: rdata_q <= out_q;
        GPIO_IN_ADDR: rdata_q <= in_q;
        default:      rdata_q <= '0;
      endcase
    end
  end

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;
  assign gpio_o    = out_q;

  // no new request while ack is still falling
  assert property (@(posedge clk_gen) disable iff (!rst_n)
    bus.ack && !bus.req |=> !bus.req);

endmodule

// File: mcu/soc_ctrl.sv
// SoC control slave: sticky exit value and exit valid, plus a
// read-write scratch register.

module soc_ctrl (
  input  logic                        clk_gen,
  input  logic                        rst_n,
  mcu_bus_if.slave                    bus,
  output logic [mcu_pkg::BUS_DW-1:0]  exit_value_o,
  output logic                        exit_valid_o
);
  import mcu_pkg::*;

  logic              ack_q;
  logic              access;
  logic [BUS_DW-1:0] exit_value_q;
  logic              exit_valid_q;
  logic [BUS_DW-1:0] scratch_q;
  logic [BUS_DW-1:0] rdata_q;

  assign access = bus.req && !ack_q;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      ack_q        <= 1'b0;
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
    end else begin
      ack_q <= bus.req;
      // valid stays up until reset
      if (access && bus.we && bus.addr == SOC_EXIT_ADDR) begin
        exit_value_q <= bus.wdata;
        exit_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_gen) begin
    if (access && bus.we && bus.addr == SOC_SCRATCH_ADDR) begin
      scratch_q <= bus.wdata;
    end
    if (access && !bus.we) begin
      case (bus.addr)
        SOC_EXIT_ADDR:    rdata_q <= exit_value_q;
        SOC_SCRATCH_ADDR: rdata_q <= scratch_q;
        default:          rdata_q <= '0;
      endcase
    end
  end

  assign bus.ack      = ack_q;
  assign bus.rdata    = rdata_q;
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

endmodule

// File: mcu/mcu_system.sv
// MCU system: command sequencer, program memory, GPIO and SoC control
// slaves, plus the address decode that steers the register bus.

module mcu_system (
  input  logic                        clk_gen,
  input  logic                        rst_n,
  input  logic                        fetch_enable_i,
  input  logic                        boot_select_i,
  input  logic [mcu_pkg::BUS_DW-1:0]  gpio_i,
  input  logic                        load_req_i,
  input  logic [mcu_pkg::MEM_AW-1:0]  load_addr_i,
  input  logic [mcu_pkg::CMD_W-1:0]   load_data_i,
  output logic                        load_ack_o,
  output logic [mcu_pkg::BUS_DW-1:0]  gpio_o,
  output logic [mcu_pkg::BUS_DW-1:0]  exit_value_o,
  output logic                        exit_valid_o
);
  import mcu_pkg::*;

  logic [MEM_AW-1:0] fetch_addr;
  cmd_u              fetch_data;
  logic              sel_soc;

  mcu_bus_if bus_m ();
  mcu_bus_if bus_gpio ();
  mcu_bus_if bus_soc ();

  // addr is held by the master through the whole handshake
  assign sel_soc = bus_m.addr[BUS_SEL_BIT];

  assign bus_gpio.req   = bus_m.req & ~sel_soc;
  assign bus_gpio.we    = bus_m.we;
  assign bus_gpio.addr  = bus_m.addr;
  assign bus_gpio.wdata = bus_m.wdata;

  assign bus_soc.req    = bus_m.req & sel_soc;
  assign bus_soc.we     = bus_m.we;
  assign bus_soc.addr   = bus_m.addr;
  assign bus_soc.wdata  = bus_m.wdata;

  assign bus_m.ack   = sel_soc ? bus_soc.ack : bus_gpio.ack;
  assign bus_m.rdata = sel_soc ? bus_soc.rdata : bus_gpio.rdata;

  cmd_sequencer u_cmd_sequencer (
    .clk_gen        (clk_gen),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .boot_select_i  (boot_select_i),
    .fetch_data_i   (fetch_data),
    .fetch_addr_o   (fetch_addr),
    .bus            (bus_m.master)
  );

  prog_mem u_prog_mem (
    .clk_gen      (clk_gen),
    .rst_n        (rst_n),
    .fetch_addr_i (fetch_addr),
    .load_req_i   (load_req_i),
    .load_addr_i  (load_addr_i),
    .load_data_i  (load_data_i),
    .fetch_data_o (fetch_data),
    .load_ack_o   (load_ack_o)
  );

  gpio_regs u_gpio_regs (
    .clk_gen (clk_gen),
    .rst_n   (rst_n),
    .bus     (bus_gpio.slave),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o)
  );

  soc_ctrl u_soc_ctrl (
    .clk_gen      (clk_gen),
    .rst_n        (rst_n),
    .bus          (bus_soc.slave),
    .exit_value_o (exit_value_o),
    .exit_valid_o (exit_valid_o)
  );

endmodule

// File: logic/board_top.sv
// Board wrapper: reset synchronizer, LED blink counter and the
// MCU system instance.

module board_top #(
  parameter int CLK_LED_COUNT_LENGTH = 27
) (
  input  logic                        clk_gen,
  input  logic                        rst_n,
  input  logic                        fetch_enable_i,
  input  logic                        boot_select_i,
  input  logic [mcu_pkg::BUS_DW-1:0]  gpio_i,
  input  logic                        load_req_i,
  input  logic [mcu_pkg::MEM_AW-1:0]  load_addr_i,
  input  logic [mcu_pkg::CMD_W-1:0]   load_data_i,
  output logic                        load_ack_o,
  output logic [mcu_pkg::BUS_DW-1:0]  gpio_o,
  output logic [mcu_pkg::BUS_DW-1:0]  exit_value_o,
  output logic                        exit_valid_o,
  output logic                        rst_led_o,
  output logic                        clk_led_o
);

  logic [1:0]                        rst_sync_q;
  logic                              rst_sync_n;
  logic [CLK_LED_COUNT_LENGTH-1:0]   clk_count_q;

  // assert at once, release after two edges
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign rst_sync_n = rst_sync_q[1];
  assign rst_led_o  = rst_sync_n;

  // free running blink counter
  always_ff @(posedge clk_gen or negedge rst_sync_n) begin
    if (!rst_sync_n) begin
      clk_count_q <= '0;
    end else begin
      clk_count_q <= clk_count_q + 1'b1;
    end
  end

  assign clk_led_o = clk_count_q[CLK_LED_COUNT_LENGTH-1];

  mcu_system u_mcu_system (
    .clk_gen        (clk_gen),
    .rst_n          (rst_sync_n),
    .fetch_enable_i (fetch_enable_i),
    .boot_select_i  (boot_select_i),
    .gpio_i         (gpio_i),
    .load_req_i     (load_req_i),
    .load_addr_i    (load_addr_i),
    .load_data_i    (load_data_i),
    .load_ack_o     (load_ack_o),
    .gpio_o         (gpio_o),
    .exit_value_o   (exit_value_o),
    .exit_valid_o   (exit_valid_o)
  );

endmodule

// File: testbench/tb_board_top.sv
// Testbench for board_top: clock, reset, host loader, reference model
// of the command set, result compare and watchdog.

module tb_board_top;
  timeunit 1ns;
  timeprecision 100ps;
  import mcu_pkg::*;

  logic              clk_gen;
  logic              rst_n;
  logic              fetch_enable_i;
  logic              boot_select_i;
  logic [BUS_DW-1:0] gpio_i;
  logic              load_req_i;
  logic [MEM_AW-1:0] load_addr_i;
  logic [CMD_W-1:0]  load_data_i;
  logic              load_ack_o;
  logic [BUS_DW-1:0] gpio_o;
  logic [BUS_DW-1:0] exit_value_o;
  logic              exit_valid_o;
  logic              rst_led_o;
  logic              clk_led_o;

  // program image with ram at 0-31, boot rom at 32-35 and halt above
  logic [CMD_W-1:0]  cmd_image [64];
  logic [CMD_W-1:0]  rand_prog [10];
  int                prog_len;
  int                seed;
  logic [BUS_DW-1:0] gpio_value;
  int                watchdog_limit;

  logic [BUS_DW-1:0] exp_gpio;
  logic [BUS_DW-1:0] exp_exit;
  logic              exp_valid;
  int                exp_exit_cycle;
  int                exp_total;

  event start_compare;
  event compare_done;

  board_top #(
    .CLK_LED_COUNT_LENGTH (4)
  ) u_dut (
    .clk_gen        (clk_gen),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .boot_select_i  (boot_select_i),
    .gpio_i         (gpio_i),
    .load_req_i     (load_req_i),
    .load_addr_i    (load_addr_i),
    .load_data_i    (load_data_i),
    .load_ack_o     (load_ack_o),
    .gpio_o         (gpio_o),
    .exit_value_o   (exit_value_o),
    .exit_valid_o   (exit_valid_o),
    .rst_led_o      (rst_led_o),
    .clk_led_o      (clk_led_o)
  );

  initial begin
    clk_gen = 1'b0;
    forever #10 clk_gen = ~clk_gen;
  end

  function automatic logic [CMD_W-1:0] enc_bus(input logic [3:0] op,
      input logic [BUS_AW-1:0] addr, input logic [BUS_DW-1:0] data);
    return {op, addr, data, 4'h0};
  endfunction

  function automatic logic [CMD_W-1:0] enc_ctrl(input logic [3:0] op,
      input logic [MEM_AW-1:0] target, input logic [15:0] count);
    return {op, target, count, 6'h00};
  endfunction

  function automatic logic [BUS_DW-1:0] rand16();
    return 16'($random(seed));
  endfunction

  function automatic logic [MEM_AW-1:0] start_addr(input int test);
    return (test == 2) ? BOOT_BASE : 6'd0;
  endfunction

  // interprets cmd_image with cycle counts from the edge that sees fetch enable
  function automatic void run_reference(
    input  logic [MEM_AW-1:0] start_pc,
    input  logic [BUS_DW-1:0] gpio_in,
    output logic [BUS_DW-1:0] ref_gpio,
    output logic [BUS_DW-1:0] ref_exit,
    output logic              ref_valid,
    output int                exit_cycle,
    output int                total_cycles
  );
    logic [MEM_AW-1:0] pc;
    logic [CMD_W-1:0]  word;
    logic [3:0]        op;
    logic [BUS_AW-1:0] addr;
    logic [BUS_DW-1:0] data;
    logic [BUS_DW-1:0] acc;
    logic [BUS_DW-1:0] scratch;
    int                steps;
    bit                running;
    pc = start_pc;
    acc = '0;
    scratch = '0;
    ref_gpio = '0;
    ref_exit = '0;
    ref_valid = 1'b0;
    exit_cycle = -1;
    total_cycles = 1;
    running = 1'b1;
    steps = 0;
    while (running && steps < 256) begin
      word = cmd_image[pc];
      op = word[31:28];
      addr = word[27:20];
      data = word[19:4];
      steps++;
      case (op)
        OP_WRITE, OP_WRITE_ACC: begin
          if (op == OP_WRITE_ACC) begin
            data = acc ^ data;
          end
          case (addr)
            GPIO_OUT_ADDR: ref_gpio = data;
            GPIO_SET_ADDR: ref_gpio = ref_gpio | data;
            GPIO_CLR_ADDR: ref_gpio = ref_gpio & ~data;
            SOC_SCRATCH_ADDR: scratch = data;
            SOC_EXIT_ADDR: begin
              // slave stores on the first req cycle after decode
              if (!ref_valid) begin
                exit_cycle = total_cycles + 2;
              end
              ref_exit = data;
              ref_valid = 1'b1;
            end
            default: ;
          endcase
          total_cycles = total_cycles + 5;
          pc = pc + 6'd1;
        end
        OP_READ: begin
          case (addr)
            GPIO_OUT_ADDR, GPIO_SET_ADDR, GPIO_CLR_ADDR: acc = ref_gpio;
            GPIO_IN_ADDR: acc = gpio_in;
            SOC_EXIT_ADDR: acc = ref_exit;
            SOC_SCRATCH_ADDR: acc = scratch;
            default: acc = '0;
          endcase
          total_cycles = total_cycles + 5;
          pc = pc + 6'd1;
        end
        OP_WAIT: begin
          total_cycles = total_cycles + int'(word[21:6]) + 2;
          pc = pc + 6'd1;
        end
        OP_JUMP: begin
          total_cycles = total_cycles + 2;
          pc = word[27:22];
        end
        default: begin
          total_cycles = total_cycles + 1;
          running = 1'b0;
        end
      endcase
    end
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_gpio(input logic [BUS_DW-1:0] actual,
      input logic [BUS_DW-1:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("[FAIL] gpio_o: got 0x%04h, expected 0x%04h", actual, expected));
    end
  endtask

  task automatic check_exit(input logic [BUS_DW-1:0] actual,
      input logic [BUS_DW-1:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("[FAIL] exit_value_o: got 0x%04h, expected 0x%04h",
                          actual, expected));
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  // inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_gen);
    #2;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    fetch_enable_i = 1'b0;
    load_req_i = 1'b0;
    repeat (2) next_cycle();
    rst_n = 1'b1;
    // synchronizer releases on the second edge
    next_cycle();
    check_bit("rst_led_o", rst_led_o, 1'b0);
    next_cycle();
    check_bit("rst_led_o", rst_led_o, 1'b1);
  endtask

  task automatic load_word(input logic [MEM_AW-1:0] addr, input logic [CMD_W-1:0] data);
    load_addr_i = addr;
    load_data_i = data;
    load_req_i = 1'b1;
    next_cycle();
    while (!load_ack_o) begin
      next_cycle();
    end
    load_req_i = 1'b0;
    next_cycle();
    while (load_ack_o) begin
      next_cycle();
    end
  endtask

  task automatic build_random_program();
    rand_prog[0] = enc_bus(OP_WRITE, GPIO_OUT_ADDR, rand16());
    rand_prog[1] = enc_bus(OP_WRITE, GPIO_SET_ADDR, rand16());
    rand_prog[2] = enc_bus(OP_WRITE, GPIO_CLR_ADDR, rand16());
    rand_prog[3] = enc_bus(OP_WRITE, SOC_SCRATCH_ADDR, rand16());
    rand_prog[4] = enc_bus(OP_READ, GPIO_IN_ADDR, 16'h0000);
    rand_prog[5] = enc_bus(OP_WRITE, GPIO_SET_ADDR, rand16());
    rand_prog[6] = enc_bus(OP_READ, SOC_SCRATCH_ADDR, 16'h0000);
    rand_prog[7] = enc_bus(OP_READ, GPIO_OUT_ADDR, 16'h0000);
    rand_prog[8] = enc_bus(OP_WRITE_ACC, SOC_EXIT_ADDR, rand16());
    rand_prog[9] = enc_ctrl(OP_HALT, 6'd0, 16'h0000);
  endtask

  task automatic prepare_image(input int test);
    int i;
    for (i = 0; i < 64; i++) begin
      cmd_image[i] = enc_ctrl(OP_HALT, 6'(i), 16'h0000);
    end
    cmd_image[32] = enc_bus(OP_WRITE, GPIO_OUT_ADDR, 16'h00A5);
    cmd_image[33] = enc_bus(OP_READ, GPIO_IN_ADDR, 16'h0000);
    cmd_image[34] = enc_bus(OP_WRITE_ACC, SOC_EXIT_ADDR, 16'h0000);
    prog_len = 0;
    case (test)
      3: begin
        for (i = 0; i < 10; i++) begin
          cmd_image[i] = rand_prog[i];
        end
        prog_len = 10;
      end
      4: begin
        // the write at 2 is jumped over
        cmd_image[0] = enc_bus(OP_WRITE, GPIO_OUT_ADDR, 16'h1234);
        cmd_image[1] = enc_ctrl(OP_JUMP, 6'd3, 16'h0000);
        cmd_image[2] = enc_bus(OP_WRITE, GPIO_OUT_ADDR, 16'hDEAD);
        cmd_image[3] = enc_ctrl(OP_WAIT, 6'd0, 16'd20);
        cmd_image[4] = enc_bus(OP_WRITE, SOC_EXIT_ADDR, 16'h5A5A);
        prog_len = 6;
      end
      5: begin
        cmd_image[0] = enc_bus(OP_WRITE, GPIO_OUT_ADDR, 16'h3C3C);
        cmd_image[1] = enc_bus(OP_WRITE, GPIO_SET_ADDR, 16'h0081);
        cmd_image[2] = {4'h7, 28'h1234567};
        cmd_image[3] = enc_bus(OP_WRITE, GPIO_OUT_ADDR, 16'hFFFF);
        cmd_image[4] = enc_bus(OP_WRITE, SOC_EXIT_ADDR, 16'h0001);
        prog_len = 5;
      end
      default: ;
    endcase
  endtask

  task automatic run_test(input int test);
    int i;
    prepare_image(test);
    run_reference(start_addr(test), gpio_value, exp_gpio, exp_exit, exp_valid,
                  exp_exit_cycle, exp_total);
    apply_reset();
    for (i = 0; i < prog_len; i++) begin
      load_word(6'(i), cmd_image[i]);
    end
    // rom region load is acked but must leave ram word 0 untouched
    load_word(BOOT_BASE, enc_bus(OP_WRITE, GPIO_OUT_ADDR, 16'hFFFF));
    boot_select_i = (test == 2);
    fetch_enable_i = 1'b1;
    -> start_compare;
    @(compare_done);
    fetch_enable_i = 1'b0;
    boot_select_i = 1'b0;
  endtask

  initial begin : compare_results
    int n;
    forever begin
      @(start_compare);
      n = 0;
      if (exp_valid) begin
        while (!exit_valid_o) begin
          next_cycle();
          n++;
        end
        if (n < exp_exit_cycle + 1) begin
          abort_run($sformatf("exit_valid_o rose after %0d cycles, earliest allowed is %0d",
                              n, exp_exit_cycle + 1));
        end
      end else begin
        // halt-only program needs a settling time
        repeat (exp_total + 4) next_cycle();
      end
      check_gpio(gpio_o, exp_gpio);
      check_exit(exit_value_o, exp_exit);
      check_bit("exit_valid_o", exit_valid_o, exp_valid);
      -> compare_done;
    end
  end

  initial begin : watchdog
    wait (watchdog_limit > 0);
    repeat (watchdog_limit) @(posedge clk_gen);
    abort_run($sformatf("watchdog expired after %0d cycles, a program never finished",
                        watchdog_limit));
  end

  initial begin : main_sequence
    int                t;
    int                i;
    int                budget;
    int                tot;
    int                cyc;
    logic [BUS_DW-1:0] g;
    logic [BUS_DW-1:0] e;
    logic              v;
    rst_n = 1'b0;
    fetch_enable_i = 1'b0;
    boot_select_i = 1'b0;
    gpio_i = '0;
    load_req_i = 1'b0;
    load_addr_i = '0;
    load_data_i = '0;
    seed = 32'h4989bb26;
    gpio_value = rand16();
    build_random_program();
    budget = 0;
    for (t = 2; t <= 5; t++) begin
      prepare_image(t);
      run_reference(start_addr(t), gpio_value, g, e, v, cyc, tot);
      budget = budget + tot;
    end
    watchdog_limit = budget + 200;

    apply_reset();
    check_gpio(gpio_o, 16'h0000);
    check_exit(exit_value_o, 16'h0000);
    check_bit("exit_valid_o", exit_valid_o, 1'b0);
    check_bit("load_ack_o", load_ack_o, 1'b0);
    // led msb of a 4-bit counter
    for (i = 1; i <= 8; i++) begin
      next_cycle();
      check_bit("clk_led_o", clk_led_o, i == 8);
    end
    gpio_i = gpio_value;

    for (t = 2; t <= 5; t++) begin
      run_test(t);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: verilog.f
common/mcu_pkg.sv
common/mcu_bus_if.sv
mcu/cmd_sequencer.sv
mcu/prog_mem.sv
mcu/gpio_regs.sv
mcu/soc_ctrl.sv
mcu/mcu_system.sv
logic/board_top.sv
testbench/tb_board_top.sv

// File: Makefile
TOP := tb_board_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP)

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir
